// ==== logic/resp_bank_pkg.sv ====
// Response bank shared definitions
// Default bank sizes and the vector types that carry a meaning

`default_nettype none

package resp_bank_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  // Greatest number of identifiers the types can hold
  localparam int unsigned MaxIds = 4;
  // Greatest number of slots in the shared memory
  localparam int unsigned MaxCapacity = 8;

  localparam int unsigned IdWidth = $clog2(MaxIds);
  localparam int unsigned SlotWidth = $clog2(MaxCapacity);
  // One more bit so a count can reach the full capacity
  localparam int unsigned CountWidth = $clog2(MaxCapacity + 1);
  localparam int unsigned PayloadWidth = 8;

  ////////////////////
  // Types
  ////////////////////

  // Identifier of a response
  typedef logic [IdWidth-1:0] id_t;
  // One bit per identifier
  typedef logic [MaxIds-1:0] id_mask_t;
  // Slot address in the shared memory
  typedef logic [SlotWidth-1:0] slot_t;
  // One bit per slot
  typedef logic [MaxCapacity-1:0] slot_mask_t;
  // Slots reserved or stored for one identifier
  typedef logic [CountWidth-1:0] count_t;
  // Response content without the identifier
  typedef logic [PayloadWidth-1:0] payload_t;

endpackage

`default_nettype wire

// ==== logic/slot_allocator.sv ====
// Slot allocator for the response bank
// Occupied bit per slot, lowest free slot search and slot freeing

`timescale 1ns/1ps
`default_nettype none

module slot_allocator import resp_bank_pkg::*; #(
  parameter int unsigned Capacity = MaxCapacity
) (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire logic       i_rsv_fire,
  input  wire logic       i_free_slot_valid,
  input  wire slot_t      i_free_slot,
  output      logic       o_rsv_ready,
  output      slot_t      o_free_addr,
  output      slot_mask_t o_released_onehot
);

  slot_mask_t occupied_q;
  slot_mask_t free_mask;
  slot_mask_t rsv_onehot;
  slot_mask_t free_onehot;

  // Free slots, limited to the configured capacity
  always_comb begin
    free_mask = '0;
    for (int i = 0; i < Capacity; i++) begin
      free_mask[i] = ~occupied_q[i];
    end
  end

  // Lowest free slot wins, scan from the top down
  always_comb begin
    o_free_addr = '0;
    for (int i = Capacity - 1; i >= 0; i--) begin
      if (free_mask[i]) begin
        o_free_addr = slot_t'(i);
      end
    end
  end

  assign o_rsv_ready = |free_mask;

  // One-hot views of the reserved and freed slots
  always_comb begin
    rsv_onehot = '0;
    free_onehot = '0;
    if (i_rsv_fire) begin
      rsv_onehot[o_free_addr] = 1'b1;
    end
    if (i_free_slot_valid) begin
      free_onehot[i_free_slot] = 1'b1;
    end
  end

  assign o_released_onehot = free_onehot;

  // Reserved slot is free and freed slot is occupied, so the two never overlap
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occupied_q <= '0;
    end else begin
      occupied_q <= (occupied_q | rsv_onehot) & ~free_onehot;
    end
  end

endmodule

`default_nettype wire

// ==== logic/id_queue_ctrl.sv ====
// Per-identifier queue controller
// Reserve tail, write pointer and read head of one linked list
// Reserved and stored counters

`timescale 1ns/1ps
`default_nettype none

module id_queue_ctrl import resp_bank_pkg::*; (
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  input  wire logic  i_rsv_fire,
  input  wire slot_t i_rsv_slot,
  input  wire logic  i_in_fire,
  input  wire logic  i_pop,
  input  wire slot_t i_link_at_wr,
  input  wire slot_t i_link_at_rd,
  output      slot_t o_rsv_tail,
  output      slot_t o_wr_ptr,
  output      slot_t o_rd_head,
  output      logic  o_has_rsv,
  output      logic  o_has_msg
);

  // List order from the head: stored slots, then reserved slots up to the tail
  slot_t  rsv_tail_q;
  slot_t  wr_ptr_q;
  slot_t  rd_head_q;
  count_t rsv_cnt_q;
  count_t msg_cnt_q;

  count_t list_len;
  count_t len_after_pop;
  count_t rsv_after_in;

  assign list_len = rsv_cnt_q + msg_cnt_q;
  // List length once this cycle's output has left
  assign len_after_pop = list_len - count_t'(i_pop);
  // Unfilled reservations once this cycle's input is written
  assign rsv_after_in = rsv_cnt_q - count_t'(i_in_fire);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsv_tail_q <= '0;
      wr_ptr_q <= '0;
      rd_head_q <= '0;
      rsv_cnt_q <= '0;
      msg_cnt_q <= '0;
    end else begin
      // New reservation always becomes the tail
      if (i_rsv_fire) begin
        rsv_tail_q <= i_rsv_slot;
      end

      // No unfilled reservation left, so the new slot is the next to fill
      // The link at the old tail is written in this same cycle and not yet readable
      if (i_rsv_fire && rsv_after_in == '0) begin
        wr_ptr_q <= i_rsv_slot;
      end else if (i_in_fire) begin
        wr_ptr_q <= i_link_at_wr;
      end

      // Empty list restarts at the new slot
      if (i_rsv_fire && len_after_pop == '0) begin
        rd_head_q <= i_rsv_slot;
      end else if (i_pop) begin
        rd_head_q <= i_link_at_rd;
      end

      rsv_cnt_q <= rsv_after_in + count_t'(i_rsv_fire);
      msg_cnt_q <= msg_cnt_q + count_t'(i_in_fire) - count_t'(i_pop);
    end
  end

  assign o_rsv_tail = rsv_tail_q;
  assign o_wr_ptr = wr_ptr_q;
  assign o_rd_head = rd_head_q;
  assign o_has_rsv = (rsv_cnt_q != '0);
  assign o_has_msg = (msg_cnt_q != '0);

endmodule

`default_nettype wire

// ==== logic/link_ram.sv ====
// Link memory of the response bank
// Next-slot pointer per slot, one write port, two reads per identifier

`timescale 1ns/1ps
`default_nettype none

module link_ram import resp_bank_pkg::*; #(
  parameter int unsigned NumIds   = MaxIds,
  parameter int unsigned Capacity = MaxCapacity
) (
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  input  wire logic  i_wr_en,
  input  wire slot_t i_wr_addr,
  input  wire slot_t i_wr_next,
  input  wire slot_t i_rd_addr_wr   [NumIds],
  input  wire slot_t i_rd_addr_head [NumIds],
  output      slot_t o_next_wr      [NumIds],
  output      slot_t o_next_head    [NumIds]
);

  slot_t next_q [Capacity];

  // Entry written when a reservation extends a list that is not empty
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      next_q <= '{default: '0};
    end else if (i_wr_en) begin
      next_q[i_wr_addr] <= i_wr_next;
    end
  end

  // Combinational reads at each queue's write pointer and read head
  always_comb begin
    for (int i = 0; i < NumIds; i++) begin
      o_next_wr[i] = next_q[i_rd_addr_wr[i]];
      o_next_head[i] = next_q[i_rd_addr_head[i]];
    end
  end

endmodule

`default_nettype wire

// ==== logic/msg_ram.sv ====
// Message memory of the response bank
// Payload flop array, one write port and one combinational read port

`timescale 1ns/1ps
`default_nettype none

module msg_ram import resp_bank_pkg::*; #(
  parameter int unsigned Capacity = MaxCapacity
) (
  input  wire logic     clk_i,
  input  wire logic     i_wr_en,
  input  wire slot_t    i_wr_addr,
  input  wire payload_t i_wr_data,
  input  wire slot_t    i_rd_addr,
  output      payload_t o_rd_data
);

  payload_t mem_q [Capacity];

  // Write on input handshake
  always_ff @(posedge clk_i) begin
    if (i_wr_en) begin
      mem_q[i_wr_addr] <= i_wr_data;
    end
  end

  // Read at the registered output slot
  assign o_rd_data = mem_q[i_rd_addr];

endmodule

`default_nettype wire

// ==== logic/release_arbiter.sv ====
// Release arbiter of the response bank
// Eligible mask, lowest identifier pick and registered output slot

`timescale 1ns/1ps
`default_nettype none

module release_arbiter import resp_bank_pkg::*; #(
  parameter int unsigned NumIds = MaxIds
) (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire id_mask_t   i_has_msg,
  input  wire slot_t      i_rd_head [NumIds],
  input  wire slot_mask_t i_release_en,
  input  wire logic       i_out_ready,
  output      logic       o_out_valid,
  output      id_t        o_out_id,
  output      slot_t      o_out_slot,
  output      id_mask_t   o_pop,
  output      logic       o_free_slot_valid
);

  logic  out_valid_q;
  id_t   out_id_q;
  slot_t out_slot_q;

  logic [NumIds-1:0] eligible;
  id_t   pick_id;
  slot_t pick_slot;
  logic  out_fire;

  // Oldest stored slot of the identifier must be enabled
  // Lowest identifier wins, scan from the top down
  always_comb begin
    eligible = '0;
    pick_id = '0;
    pick_slot = '0;
    for (int i = NumIds - 1; i >= 0; i--) begin
      eligible[i] = i_has_msg[i] && i_release_en[i_rd_head[i]];
      if (eligible[i]) begin
        pick_id = id_t'(i);
        pick_slot = i_rd_head[i];
      end
    end
  end

  assign out_fire = out_valid_q && i_out_ready;

  ////////////////////
  // Output register
  ////////////////////

  // Reload only when empty, so a handshake always leaves one idle cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
      out_id_q <= '0;
      out_slot_q <= '0;
    end else if (out_fire) begin
      out_valid_q <= 1'b0;
    end else if (!out_valid_q && |eligible) begin
      out_valid_q <= 1'b1;
      out_id_q <= pick_id;
      out_slot_q <= pick_slot;
    end
  end

  // Pop strobe back to the owning queue
  always_comb begin
    o_pop = '0;
    if (out_fire) begin
      o_pop[out_id_q] = 1'b1;
    end
  end

  assign o_out_valid = out_valid_q;
  assign o_out_id = out_id_q;
  assign o_out_slot = out_slot_q;
  assign o_free_slot_valid = out_fire;

endmodule

`default_nettype wire

// ==== logic/resp_bank_top.sv ====
// Response bank top level
// Slot allocator, per-identifier queues, arbiter and the two memories

`timescale 1ns/1ps
`default_nettype none

module resp_bank_top import resp_bank_pkg::*; #(
  parameter int unsigned NumIds   = MaxIds,
  parameter int unsigned Capacity = MaxCapacity
) (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  // Reservation
  input  wire logic       i_rsv_valid,
  input  wire id_t        i_rsv_id,
  output      logic       o_rsv_ready,
  output      slot_t      o_rsv_addr,
  // Response input
  input  wire logic       i_in_valid,
  input  wire id_t        i_in_id,
  input  wire payload_t   i_in_payload,
  output      logic       o_in_ready,
  // Release enable and output
  input  wire slot_mask_t i_release_en,
  output      logic       o_out_valid,
  output      id_t        o_out_id,
  output      payload_t   o_out_payload,
  input  wire logic       i_out_ready,
  output      slot_mask_t o_released_onehot
);

  logic     rsv_fire;
  logic     in_fire;
  id_mask_t has_rsv;
  id_mask_t has_msg;
  id_mask_t pop;
  slot_t    rsv_tail  [NumIds];
  slot_t    wr_ptr    [NumIds];
  slot_t    rd_head   [NumIds];
  slot_t    link_wr   [NumIds];
  slot_t    link_rd   [NumIds];
  slot_t    out_slot;
  logic     free_valid;
  slot_t    msg_wr_addr;
  slot_t    link_wr_addr;
  logic     link_wr_en;

  assign rsv_fire = i_rsv_valid && o_rsv_ready;
  // Ready follows valid, accepted only against an unfilled reservation
  assign o_in_ready = i_in_valid && has_rsv[i_in_id];
  assign in_fire = o_in_ready;

  slot_allocator #(
    .Capacity (Capacity)
  ) u_alloc (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .i_rsv_fire        (rsv_fire),
    .i_free_slot_valid (free_valid),
    .i_free_slot       (out_slot),
    .o_rsv_ready       (o_rsv_ready),
    .o_free_addr       (o_rsv_addr),
    .o_released_onehot (o_released_onehot)
  );

  ////////////////////
  // Identifier queues
  ////////////////////

  for (genvar g = 0; g < NumIds; g++) begin : gen_queue
    id_queue_ctrl u_queue (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .i_rsv_fire   (rsv_fire && (i_rsv_id == id_t'(g))),
      .i_rsv_slot   (o_rsv_addr),
      .i_in_fire    (in_fire && (i_in_id == id_t'(g))),
      .i_pop        (pop[g]),
      .i_link_at_wr (link_wr[g]),
      .i_link_at_rd (link_rd[g]),
      .o_rsv_tail   (rsv_tail[g]),
      .o_wr_ptr     (wr_ptr[g]),
      .o_rd_head    (rd_head[g]),
      .o_has_rsv    (has_rsv[g]),
      .o_has_msg    (has_msg[g])
    );
  end

  // Identifiers above the configured count never hold anything
  for (genvar g = NumIds; g < MaxIds; g++) begin : gen_unused_id
    assign has_rsv[g] = 1'b0;
    assign has_msg[g] = 1'b0;
  end

  // Write address and link update of the active identifiers
  always_comb begin
    msg_wr_addr = '0;
    link_wr_addr = '0;
    link_wr_en = 1'b0;
    for (int i = 0; i < NumIds; i++) begin
      if (i_in_id == id_t'(i)) begin
        msg_wr_addr = wr_ptr[i];
      end
      // Chain the new slot behind the tail of a list that is not empty
      if (i_rsv_id == id_t'(i)) begin
        link_wr_addr = rsv_tail[i];
        link_wr_en = rsv_fire && (has_rsv[i] || has_msg[i]);
      end
    end
  end

  link_ram #(
    .NumIds   (NumIds),
    .Capacity (Capacity)
  ) u_link (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .i_wr_en        (link_wr_en),
    .i_wr_addr      (link_wr_addr),
    .i_wr_next      (o_rsv_addr),
    .i_rd_addr_wr   (wr_ptr),
    .i_rd_addr_head (rd_head),
    .o_next_wr      (link_wr),
    .o_next_head    (link_rd)
  );

  msg_ram #(
    .Capacity (Capacity)
  ) u_msg (
    .clk_i     (clk_i),
    .i_wr_en   (in_fire),
    .i_wr_addr (msg_wr_addr),
    .i_wr_data (i_in_payload),
    .i_rd_addr (out_slot),
    .o_rd_data (o_out_payload)
  );

  release_arbiter #(
    .NumIds (NumIds)
  ) u_arb (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .i_has_msg         (has_msg),
    .i_rd_head         (rd_head),
    .i_release_en      (i_release_en),
    .i_out_ready       (i_out_ready),
    .o_out_valid       (o_out_valid),
    .o_out_id          (o_out_id),
    .o_out_slot        (out_slot),
    .o_pop             (pop),
    .o_free_slot_valid (free_valid)
  );

endmodule

`default_nettype wire

// ==== verif/tb_resp_bank.sv ====
// Directed testbench for the response bank
// Reference lists per identifier, free-slot model, compare tasks and watchdog

`timescale 1ns/1ps
`default_nettype none

module tb_resp_bank import resp_bank_pkg::*; ();

  localparam int NumIds     = 4;
  localparam int Capacity   = 8;
  localparam int ClkPeriod  = 4;
  // Clock edges from the start of reset to the end of the last test
  localparam int TestCycles = 67;
  localparam int WaitLimit  = 16;

  logic       clk_i;
  logic       rst_ni;
  logic       rsv_valid;
  id_t        rsv_id;
  logic       rsv_ready;
  slot_t      rsv_addr;
  logic       in_valid;
  id_t        in_id;
  payload_t   in_payload;
  logic       in_ready;
  slot_mask_t release_en;
  logic       out_valid;
  id_t        out_id;
  payload_t   out_payload;
  logic       out_ready;
  slot_mask_t released_onehot;

  // Reference model of the slots per identifier in reservation order
  slot_t      list_m [NumIds][$];
  // Filled entries counted from the list head
  int         fill_m [NumIds];
  payload_t   pay_m  [Capacity];
  slot_mask_t occ_m;
  int         seed;

  resp_bank_top #(
    .NumIds   (NumIds),
    .Capacity (Capacity)
  ) dut0 (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .i_rsv_valid       (rsv_valid),
    .i_rsv_id          (rsv_id),
    .o_rsv_ready       (rsv_ready),
    .o_rsv_addr        (rsv_addr),
    .i_in_valid        (in_valid),
    .i_in_id           (in_id),
    .i_in_payload      (in_payload),
    .o_in_ready        (in_ready),
    .i_release_en      (release_en),
    .o_out_valid       (out_valid),
    .o_out_id          (out_id),
    .o_out_payload     (out_payload),
    .i_out_ready       (out_ready),
    .o_released_onehot (released_onehot)
  );

  initial clk_i = 1'b0;
  always #(ClkPeriod / 2) clk_i = ~clk_i;

  ////////////////////
  // Checking
  ////////////////////

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic compare_slot(input slot_t act, input slot_t exp, input string what);
    if (act !== exp) begin
      stop_with_error($sformatf("MISMATCH at %0t: %s is %0d, expected %0d",
                                $time, what, act, exp));
    end
  endtask

  task automatic compare_id(input id_t act, input id_t exp, input string what);
    if (act !== exp) begin
      stop_with_error($sformatf("MISMATCH at %0t: %s is %0d, expected %0d",
                                $time, what, act, exp));
    end
  endtask

  task automatic compare_payload(input payload_t act, input payload_t exp, input string what);
    if (act !== exp) begin
      stop_with_error($sformatf("MISMATCH at %0t: %s is 0x%02h, expected 0x%02h",
                                $time, what, act, exp));
    end
  endtask

  task automatic compare_mask(input slot_mask_t act, input slot_mask_t exp, input string what);
    if (act !== exp) begin
      stop_with_error($sformatf("MISMATCH at %0t: %s is %b, expected %b",
                                $time, what, act, exp));
    end
  endtask

  task automatic compare_flag(input logic act, input logic exp, input string what);
    if (act !== exp) begin
      stop_with_error($sformatf("MISMATCH at %0t: %s is %b, expected %b",
                                $time, what, act, exp));
    end
  endtask

  ////////////////////
  // Model and driving
  ////////////////////

  // Lowest slot that is not occupied
  function automatic slot_t lowest_free();
    slot_t s;
    s = '0;
    for (int i = Capacity - 1; i >= 0; i--) begin
      if (!occ_m[i]) begin
        s = slot_t'(i);
      end
    end
    return s;
  endfunction

  // Lowest identifier whose oldest slot is filled and enabled
  // Returns -1 when no identifier qualifies
  function automatic int expected_id();
    for (int i = 0; i < NumIds; i++) begin
      if (fill_m[i] > 0 && release_en[list_m[i][0]]) begin
        return i;
      end
    end
    return -1;
  endfunction

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic reserve(input id_t id);
    slot_t exp_slot;
    exp_slot = lowest_free();
    rsv_valid = 1'b1;
    rsv_id = id;
    #1;
    compare_flag(rsv_ready, logic'(occ_m != '1), "reservation ready");
    compare_slot(rsv_addr, exp_slot, "reserved slot");
    occ_m[exp_slot] = 1'b1;
    list_m[id].push_back(exp_slot);
    next_cycle();
    rsv_valid = 1'b0;
  endtask

  task automatic send_input(input id_t id, input payload_t payload);
    in_valid = 1'b1;
    in_id = id;
    in_payload = payload;
    #1;
    compare_flag(in_ready, logic'(fill_m[id] < list_m[id].size()), "input ready");
    // Fills the oldest unfilled reservation
    pay_m[list_m[id][fill_m[id]]] = payload;
    fill_m[id]++;
    next_cycle();
    in_valid = 1'b0;
  endtask

  task automatic check_blocked_input(input id_t id);
    in_valid = 1'b1;
    in_id = id;
    repeat (2) begin
      #1;
      compare_flag(in_ready, 1'b0, "input ready without reservation");
      next_cycle();
    end
    in_valid = 1'b0;
  endtask

  task automatic wait_out_valid();
    int waited;
    waited = 0;
    while (out_valid !== 1'b1) begin
      if (waited == WaitLimit) begin
        stop_with_error("Output valid never rose although a message was eligible");
      end
      waited++;
      next_cycle();
    end
  endtask

  task automatic expect_release();
    int    exp_id;
    slot_t exp_slot;
    exp_id = expected_id();
    if (exp_id < 0) begin
      stop_with_error("No identifier in the model is eligible for release");
    end
    exp_slot = list_m[exp_id][0];
    wait_out_valid();
    compare_id(out_id, id_t'(exp_id), "output id");
    compare_payload(out_payload, pay_m[exp_slot], "output payload");
    out_ready = 1'b1;
    #1;
    compare_mask(released_onehot, slot_mask_t'(1) << exp_slot, "released slot");
    next_cycle();
    void'(list_m[exp_id].pop_front());
    fill_m[exp_id]--;
    occ_m[exp_slot] = 1'b0;
    // Register empties and the freed slot is back in the pool
    compare_mask(released_onehot, '0, "released slot after handshake");
    compare_flag(out_valid, 1'b0, "output valid after handshake");
    compare_slot(rsv_addr, lowest_free(), "next free slot");
    out_ready = 1'b0;
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_reset();
    #1;
    compare_flag(rsv_ready, 1'b1, "reservation ready after reset");
    compare_slot(rsv_addr, '0, "free slot after reset");
    compare_flag(out_valid, 1'b0, "output valid after reset");
    compare_flag(in_ready, 1'b0, "input ready after reset");
    compare_mask(released_onehot, '0, "released slot after reset");
    next_cycle();
    check_blocked_input(2'd0);
  endtask

  task automatic test_allocation();
    id_t owner [8] = '{2'd1, 2'd2, 2'd1, 2'd0, 2'd3, 2'd2, 2'd1, 2'd0};
    for (int i = 0; i < 8; i++) begin
      reserve(owner[i]);
    end
    // Every slot taken
    compare_flag(rsv_ready, 1'b0, "reservation ready when full");
  endtask

  task automatic test_input_gating();
    id_t order [7] = '{2'd1, 2'd0, 2'd2, 2'd1, 2'd0, 2'd2, 2'd1};
    send_input(2'd3, payload_t'($random(seed)));
    check_blocked_input(2'd3);
    for (int i = 0; i < 7; i++) begin
      send_input(order[i], payload_t'($random(seed)));
    end
  endtask

  task automatic test_in_order();
    // Slot 2 is the middle entry of identifier 1 and no head is enabled
    release_en = 8'b0000_0100;
    repeat (4) begin
      next_cycle();
      compare_flag(out_valid, 1'b0, "output valid with only a later slot enabled");
    end
    release_en = 8'b0100_0101;
    repeat (3) begin
      expect_release();
    end
  endtask

  task automatic test_priority();
    release_en = '0;
    reserve(2'd2);
    reserve(2'd2);
    reserve(2'd0);
    send_input(2'd2, payload_t'($random(seed)));
    send_input(2'd0, payload_t'($random(seed)));
    send_input(2'd2, payload_t'($random(seed)));
    release_en = '1;
    repeat (8) begin
      expect_release();
    end
  endtask

  task automatic test_backpressure();
    id_t      held_id;
    payload_t held_payload;
    reserve(2'd3);
    send_input(2'd3, payload_t'($random(seed)));
    wait_out_valid();
    // Identifier 3 holds the only stored message
    held_id = 2'd3;
    held_payload = pay_m[list_m[3][0]];
    // Enable drop must not touch the message already presented
    release_en = '0;
    repeat (6) begin
      next_cycle();
      compare_flag(out_valid, 1'b1, "held output valid");
      compare_id(out_id, held_id, "held output id");
      compare_payload(out_payload, held_payload, "held output payload");
    end
    release_en = '1;
    expect_release();
  endtask

  initial begin
    seed = 32'h6bb10c2b;
    occ_m = '0;
    for (int i = 0; i < NumIds; i++) begin
      fill_m[i] = 0;
    end
    rst_ni = 1'b0;
    rsv_valid = 1'b0;
    rsv_id = '0;
    in_valid = 1'b0;
    in_id = '0;
    in_payload = '0;
    release_en = '0;
    out_ready = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    test_reset();
    test_allocation();
    test_input_gating();
    test_in_order();
    test_priority();
    test_backpressure();
    $display("Test completed successfully");
    $finish;
  end

  // Twice the expected run length
  initial begin
    #(TestCycles * ClkPeriod * 2);
    $display("Timeout: the tests did not finish within the time limit");
    $display("Test failed");
    $fatal(1);
  end

endmodule

`default_nettype wire

// ==== list.f ====
logic/resp_bank_pkg.sv
logic/slot_allocator.sv
logic/id_queue_ctrl.sv
logic/link_ram.sv
logic/msg_ram.sv
logic/release_arbiter.sv
logic/resp_bank_top.sv
verif/tb_resp_bank.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_resp_bank
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
